/* Makefile */
TOP = tb_core

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+verification
src/core_pkg.sv
src/regfile.sv
src/decode_issue.sv
src/instr_exec.sv
src/writeback_merge.sv
src/cpu_core.sv
verification/tb_core.sv

/* src/core_pkg.sv */
package core_pkg;

	// machine shape
	localparam int ISSUE_NUM  = 2;
	localparam int REG_NUM    = 32;
	localparam int WORD_WIDTH = 32;
	localparam int REG_AW     = 5;
	localparam int IMM_WIDTH  = 13;

	// lui places the immediate at the top of the word
	localparam int LUI_SHIFT = WORD_WIDTH - IMM_WIDTH;

	typedef logic [WORD_WIDTH-1:0] word_t;
	typedef logic [WORD_WIDTH-1:0] instr_t;
	typedef logic [REG_AW-1:0]     reg_addr_t;
	typedef logic [IMM_WIDTH-1:0]  imm_t;
	typedef logic [3:0]            opcode_t;

	// opcode field, bits 31:28
	localparam opcode_t OPC_NOP  = 4'h0;
	localparam opcode_t OPC_ADD  = 4'h1;
	localparam opcode_t OPC_SUB  = 4'h2;
	localparam opcode_t OPC_AND  = 4'h3;
	localparam opcode_t OPC_OR   = 4'h4;
	localparam opcode_t OPC_XOR  = 4'h5;
	localparam opcode_t OPC_SLT  = 4'h6;
	localparam opcode_t OPC_SLL  = 4'h7;
	localparam opcode_t OPC_ADDI = 4'h8;
	localparam opcode_t OPC_LUI  = 4'h9;

	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_ADD  = 4'd1,
		OP_SUB  = 4'd2,
		OP_AND  = 4'd3,
		OP_OR   = 4'd4,
		OP_XOR  = 4'd5,
		// signed compare
		OP_SLT  = 4'd6,
		// shift amount from rt[4:0]
		OP_SLL  = 4'd7,
		OP_ADDI = 4'd8,
		OP_LUI  = 4'd9
	} alu_op_e;

endpackage

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid_i,
	input  core_pkg::instr_t    instr0_i,
	input  core_pkg::instr_t    instr1_i,
	output logic                instr_ready_o,
	output logic [1:0]          retire_valid_o,
	output core_pkg::reg_addr_t retire_rd0_o,
	output core_pkg::reg_addr_t retire_rd1_o,
	output core_pkg::word_t     retire_data0_o,
	output core_pkg::word_t     retire_data1_o
);
	import core_pkg::*;

	// decode outputs
	logic [1:0] issue_valid;
	alu_op_e    issue_op [2];
	reg_addr_t  issue_rd [2];
	reg_addr_t  issue_rs [2];
	reg_addr_t  issue_rt [2];
	imm_t       issue_imm [2];

	// ID/EX
	logic [1:0] idex_valid;
	alu_op_e    idex_op [2];
	reg_addr_t  idex_rd [2];
	reg_addr_t  idex_rs [2];
	reg_addr_t  idex_rt [2];
	imm_t       idex_imm [2];

	// lane results
	word_t      ex_result [2];
	logic [1:0] ex_wr;

	// EX/WB
	logic [1:0] exwb_valid;
	logic [1:0] exwb_wr;
	reg_addr_t  exwb_rd [2];
	word_t      exwb_data [2];

	// regfile and forwarding
	logic [1:0] rf_we;
	reg_addr_t  rf_waddr [2];
	word_t      rf_wdata [2];
	reg_addr_t  rf_raddr [4];
	word_t      rf_rdata [4];
	logic [1:0] fwd_we;
	reg_addr_t  fwd_addr [2];
	word_t      fwd_data [2];

	decode_issue decode_issue_inst (
		.clk,
		.rst,
		.instr_valid_i,
		.instr0_i,
		.instr1_i,
		.instr_ready_o,
		.issue_valid_o ( issue_valid ),
		.issue_op_o    ( issue_op    ),
		.issue_rd_o    ( issue_rd    ),
		.issue_rs_o    ( issue_rs    ),
		.issue_rt_o    ( issue_rt    ),
		.issue_imm_o   ( issue_imm   )
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			idex_valid <= '0;
			for (int i = 0; i < ISSUE_NUM; i++) begin
				idex_op[i]  <= OP_NOP;
				idex_rd[i]  <= '0;
				idex_rs[i]  <= '0;
				idex_rt[i]  <= '0;
				idex_imm[i] <= '0;
			end
		end else begin
			idex_valid <= issue_valid;
			idex_op    <= issue_op;
			idex_rd    <= issue_rd;
			idex_rs    <= issue_rs;
			idex_rt    <= issue_rt;
			idex_imm   <= issue_imm;
		end
	end

	regfile regfile_inst (
		.clk,
		.rst,
		.we_i    ( rf_we    ),
		.waddr_i ( rf_waddr ),
		.wdata_i ( rf_wdata ),
		.raddr_i ( rf_raddr ),
		.rdata_o ( rf_rdata )
	);

	// lane i owns read ports 2i and 2i+1
	for (genvar i = 0; i < ISSUE_NUM; i++) begin : gen_lane
		reg_addr_t lane_raddr [2];
		word_t     lane_rdata [2];

		assign rf_raddr[2*i]   = lane_raddr[0];
		assign rf_raddr[2*i+1] = lane_raddr[1];
		assign lane_rdata[0]   = rf_rdata[2*i];
		assign lane_rdata[1]   = rf_rdata[2*i+1];

		instr_exec exec_inst (
			.op_i       ( idex_op[i]    ),
			.rd_i       ( idex_rd[i]    ),
			.rs_i       ( idex_rs[i]    ),
			.rt_i       ( idex_rt[i]    ),
			.imm_i      ( idex_imm[i]   ),
			.valid_i    ( idex_valid[i] ),
			.raddr_o    ( lane_raddr    ),
			.rdata_i    ( lane_rdata    ),
			.fwd_we_i   ( fwd_we        ),
			.fwd_addr_i ( fwd_addr      ),
			.fwd_data_i ( fwd_data      ),
			.result_o   ( ex_result[i]  ),
			.wr_o       ( ex_wr[i]      )
		);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exwb_valid <= '0;
			exwb_wr    <= '0;
			for (int i = 0; i < ISSUE_NUM; i++) begin
				exwb_rd[i]   <= '0;
				exwb_data[i] <= '0;
			end
		end else begin
			exwb_valid <= idex_valid;
			exwb_wr    <= ex_wr;
			exwb_rd    <= idex_rd;
			exwb_data  <= ex_result;
		end
	end

	writeback_merge writeback_merge_inst (
		.wb_valid_i ( exwb_valid ),
		.wb_wr_i    ( exwb_wr    ),
		.wb_rd_i    ( exwb_rd    ),
		.wb_data_i  ( exwb_data  ),
		.we_o       ( rf_we      ),
		.waddr_o    ( rf_waddr   ),
		.wdata_o    ( rf_wdata   ),
		.fwd_we_o   ( fwd_we     ),
		.fwd_addr_o ( fwd_addr   ),
		.fwd_data_o ( fwd_data   )
	);

	// retire straight from EX/WB
	assign retire_valid_o = exwb_valid;
	assign retire_rd0_o   = exwb_rd[0];
	assign retire_rd1_o   = exwb_rd[1];
	assign retire_data0_o = exwb_data[0];
	assign retire_data1_o = exwb_data[1];

endmodule

/* src/decode_issue.sv */
`timescale 1ns/1ps

module decode_issue (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid_i,
	input  core_pkg::instr_t    instr0_i,
	input  core_pkg::instr_t    instr1_i,
	output logic                instr_ready_o,
	output logic [1:0]          issue_valid_o,
	output core_pkg::alu_op_e   issue_op_o [2],
	output core_pkg::reg_addr_t issue_rd_o [2],
	output core_pkg::reg_addr_t issue_rs_o [2],
	output core_pkg::reg_addr_t issue_rt_o [2],
	output core_pkg::imm_t      issue_imm_o [2]
);
	import core_pkg::*;

	typedef enum logic {
		ST_PAIR,
		ST_HELD
	} state_e;

	state_e state;
	state_e state_next;

	// accepted pair, instr 0 is older
	logic   pair_valid;
	instr_t pair_instr [2];
	// deferred slot 1
	instr_t hold_instr;

	instr_t slot_instr [2];
	logic   slot1_dep;
	logic   split;

	function automatic alu_op_e decode_op(input opcode_t opc);
		alu_op_e op;
		case (opc)
			OPC_ADD:  op = OP_ADD;
			OPC_SUB:  op = OP_SUB;
			OPC_AND:  op = OP_AND;
			OPC_OR:   op = OP_OR;
			OPC_XOR:  op = OP_XOR;
			OPC_SLT:  op = OP_SLT;
			OPC_SLL:  op = OP_SLL;
			OPC_ADDI: op = OP_ADDI;
			OPC_LUI:  op = OP_LUI;
			default:  op = OP_NOP;
		endcase
		return op;
	endfunction

	function automatic logic reads_rs(input alu_op_e op);
		return op != OP_NOP && op != OP_LUI;
	endfunction

	function automatic logic reads_rt(input alu_op_e op);
		return op != OP_NOP && op != OP_LUI && op != OP_ADDI;
	endfunction

	// lane 0 takes the held instruction in ST_HELD
	assign slot_instr[0] = (state == ST_HELD) ? hold_instr : pair_instr[0];
	assign slot_instr[1] = pair_instr[1];

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			issue_op_o[i]  = decode_op(slot_instr[i][31:28]);
			issue_rd_o[i]  = slot_instr[i][27:23];
			issue_rs_o[i]  = slot_instr[i][22:18];
			issue_rt_o[i]  = slot_instr[i][17:13];
			issue_imm_o[i] = slot_instr[i][12:0];
		end
	end

	// raw hazard inside the pair
	always_comb begin
		slot1_dep = 1'b0;
		if (issue_op_o[0] != OP_NOP && issue_rd_o[0] != '0) begin
			if (reads_rs(issue_op_o[1]) && issue_rs_o[1] == issue_rd_o[0]) begin
				slot1_dep = 1'b1;
			end
			if (reads_rt(issue_op_o[1]) && issue_rt_o[1] == issue_rd_o[0]) begin
				slot1_dep = 1'b1;
			end
		end
	end

	assign split         = (state == ST_PAIR) && pair_valid && slot1_dep;
	assign instr_ready_o = !split;

	assign issue_valid_o[0] = (state == ST_HELD) || pair_valid;
	assign issue_valid_o[1] = (state == ST_PAIR) && pair_valid && !split;

	assign state_next = split ? ST_HELD : ST_PAIR;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_PAIR;
			pair_valid <= 1'b0;
		end else begin
			state <= state_next;
			if (instr_ready_o) begin
				pair_valid <= instr_valid_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid_i && instr_ready_o) begin
			pair_instr[0] <= instr0_i;
			pair_instr[1] <= instr1_i;
		end
		if (split) begin
			hold_instr <= pair_instr[1];
		end
	end

	// a split costs exactly one cycle
	a_ready_one_cycle: assert property (
		@(posedge clk) disable iff (rst)
		!instr_ready_o |=> instr_ready_o
	) else $error("decode_issue: ready low for two cycles");

endmodule

/* src/instr_exec.sv */
`timescale 1ns/1ps

module instr_exec (
	input  core_pkg::alu_op_e   op_i,
	input  core_pkg::reg_addr_t rd_i,
	input  core_pkg::reg_addr_t rs_i,
	input  core_pkg::reg_addr_t rt_i,
	input  core_pkg::imm_t      imm_i,
	input  logic                valid_i,
	output core_pkg::reg_addr_t raddr_o [2],
	input  core_pkg::word_t     rdata_i [2],
	input  logic [1:0]          fwd_we_i,
	input  core_pkg::reg_addr_t fwd_addr_i [2],
	input  core_pkg::word_t     fwd_data_i [2],
	output core_pkg::word_t     result_o,
	output logic                wr_o
);
	import core_pkg::*;

	// operand 0 is rs, operand 1 is rt
	word_t opnd [2];
	word_t imm_sext;

	assign raddr_o[0] = rs_i;
	assign raddr_o[1] = rt_i;

	always_comb begin
		for (int k = 0; k < 2; k++) begin
			opnd[k] = rdata_i[k];
			// lane 1 is checked last and so overrides lane 0
			for (int l = 0; l < ISSUE_NUM; l++) begin
				if (fwd_we_i[l] && fwd_addr_i[l] == raddr_o[k] && raddr_o[k] != '0) begin
					opnd[k] = fwd_data_i[l];
				end
			end
		end
	end

	assign imm_sext = {{(WORD_WIDTH - IMM_WIDTH){imm_i[IMM_WIDTH-1]}}, imm_i};

	always_comb begin
		case (op_i)
			OP_ADD:  result_o = opnd[0] + opnd[1];
			OP_SUB:  result_o = opnd[0] - opnd[1];
			OP_AND:  result_o = opnd[0] & opnd[1];
			OP_OR:   result_o = opnd[0] | opnd[1];
			OP_XOR:  result_o = opnd[0] ^ opnd[1];
			OP_SLT:  result_o = ($signed(opnd[0]) < $signed(opnd[1])) ? word_t'(1) : '0;
			OP_SLL:  result_o = opnd[0] << opnd[1][4:0];
			OP_ADDI: result_o = opnd[0] + imm_sext;
			OP_LUI:  result_o = word_t'(imm_i) << LUI_SHIFT;
			default: result_o = '0;
		endcase
	end

	// nop never writes, r0 writes go nowhere
	assign wr_o = valid_i && op_i != OP_NOP && rd_i != '0;

endmodule

/* src/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input  logic                clk,
	input  logic                rst,
	input  logic [1:0]          we_i,
	input  core_pkg::reg_addr_t waddr_i [2],
	input  core_pkg::word_t     wdata_i [2],
	input  core_pkg::reg_addr_t raddr_i [4],
	output core_pkg::word_t     rdata_o [4]
);
	import core_pkg::*;

	word_t regs [REG_NUM];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_NUM; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// port 1 goes last so it wins on a collision
			for (int p = 0; p < ISSUE_NUM; p++) begin
				if (we_i[p] && waddr_i[p] != '0) begin
					regs[waddr_i[p]] <= wdata_i[p];
				end
			end
		end
	end

	// r0 is hard zero
	always_comb begin
		for (int r = 0; r < 2 * ISSUE_NUM; r++) begin
			if (raddr_i[r] == '0) begin
				rdata_o[r] = '0;
			end else begin
				rdata_o[r] = regs[raddr_i[r]];
			end
		end
	end

	// same-register pairs are resolved upstream in writeback_merge
	a_no_dual_write: assert property (
		@(posedge clk) disable iff (rst)
		!(we_i[0] && we_i[1] && waddr_i[0] == waddr_i[1] && waddr_i[0] != '0)
	) else $error("regfile: both write ports hit r%0d", waddr_i[0]);

endmodule

/* src/writeback_merge.sv */
`timescale 1ns/1ps

module writeback_merge (
	input  logic [1:0]          wb_valid_i,
	input  logic [1:0]          wb_wr_i,
	input  core_pkg::reg_addr_t wb_rd_i [2],
	input  core_pkg::word_t     wb_data_i [2],
	output logic [1:0]          we_o,
	output core_pkg::reg_addr_t waddr_o [2],
	output core_pkg::word_t     wdata_o [2],
	output logic [1:0]          fwd_we_o,
	output core_pkg::reg_addr_t fwd_addr_o [2],
	output core_pkg::word_t     fwd_data_o [2]
);
	import core_pkg::*;

	logic [1:0] lane_wr;

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			lane_wr[i] = wb_valid_i[i] && wb_wr_i[i] && wb_rd_i[i] != '0;
		end

		// lane 1 is younger, drop the older write to the same register
		we_o[1] = lane_wr[1];
		we_o[0] = lane_wr[0] && !(lane_wr[1] && wb_rd_i[1] == wb_rd_i[0]);
	end

	always_comb begin
		for (int i = 0; i < ISSUE_NUM; i++) begin
			waddr_o[i] = wb_rd_i[i];
			wdata_o[i] = wb_data_i[i];
		end
	end

	// execute sees exactly what the regfile will take
	always_comb begin
		fwd_we_o = we_o;
		for (int i = 0; i < ISSUE_NUM; i++) begin
			fwd_addr_o[i] = waddr_o[i];
			fwd_data_o[i] = wdata_o[i];
		end
	end

endmodule

/* verification/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// one expected retire, in program order
typedef struct packed {
	int unsigned cycle;
	int unsigned lane;
	reg_addr_t   rd;
	word_t       data;
} retire_t;

word_t   model_regs [REG_NUM];
retire_t expect_q [$];

task automatic model_reset();
	for (int i = 0; i < REG_NUM; i++) begin
		model_regs[i] = '0;
	end
	expect_q.delete();
endtask

function automatic logic op_writes(input opcode_t opc);
	return opc inside {OPC_ADD, OPC_SUB, OPC_AND, OPC_OR, OPC_XOR,
		OPC_SLT, OPC_SLL, OPC_ADDI, OPC_LUI};
endfunction

// source registers per op, lui and nop read nothing
function automatic logic reads_reg(input instr_t instr, input reg_addr_t r);
	opcode_t opc;
	opc = instr[31:28];
	if (opc == OPC_ADDI) begin
		return instr[22:18] == r;
	end
	if (opc inside {OPC_ADD, OPC_SUB, OPC_AND, OPC_OR, OPC_XOR, OPC_SLT, OPC_SLL}) begin
		return instr[22:18] == r || instr[17:13] == r;
	end
	return 1'b0;
endfunction

function automatic logic slot1_depends(input instr_t i0, input instr_t i1);
	return op_writes(i0[31:28]) && i0[27:23] != 5'd0 && reads_reg(i1, i0[27:23]);
endfunction

task automatic model_execute(input instr_t instr, input int unsigned cycle,
		input int unsigned lane);
	word_t     a;
	word_t     b;
	word_t     res;
	imm_t      imm;
	reg_addr_t rd;
	retire_t   ent;
	a   = model_regs[instr[22:18]];
	b   = model_regs[instr[17:13]];
	imm = instr[12:0];
	rd  = instr[27:23];
	case (instr[31:28])
		OPC_ADD:  res = a + b;
		OPC_SUB:  res = a - b;
		OPC_AND:  res = a & b;
		OPC_OR:   res = a | b;
		OPC_XOR:  res = a ^ b;
		OPC_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		OPC_SLL:  res = a << b[4:0];
		OPC_ADDI: res = a + {{19{imm[12]}}, imm};
		OPC_LUI:  res = {imm, 19'd0};
		default:  res = '0;
	endcase
	if (op_writes(instr[31:28]) && rd != 5'd0) begin
		model_regs[rd] = res;
	end
	ent.cycle = cycle;
	ent.lane  = lane;
	ent.rd    = rd;
	ent.data  = res;
	expect_q.push_back(ent);
endtask

// pair accepted at edge acc, retires two edges later
task automatic model_accept(input instr_t i0, input instr_t i1, input int unsigned acc,
		output logic split);
	split = slot1_depends(i0, i1);
	model_execute(i0, acc + 2, 0);
	if (split) begin
		model_execute(i1, acc + 3, 0);
	end else begin
		model_execute(i1, acc + 2, 1);
	end
endtask

`endif

/* verification/tb_core.sv */
`timescale 1ns/1ps

module tb_core;
	import core_pkg::*;

	`include "tb_model.svh"

	localparam int DIRECTED_PAIRS = 14;
	localparam int RANDOM_PAIRS   = 2000;
	localparam int TIMEOUT_CYCLES = (DIRECTED_PAIRS + RANDOM_PAIRS) * 3 + 100;

	logic        clk;
	logic        rst;
	logic        instr_valid_i;
	instr_t      instr0_i;
	instr_t      instr1_i;
	logic        instr_ready_o;
	logic [1:0]  retire_valid_o;
	reg_addr_t   retire_rd0_o;
	reg_addr_t   retire_rd1_o;
	word_t       retire_data0_o;
	word_t       retire_data1_o;

	integer      seed;
	int unsigned cycle_cnt;
	// previous pair was split, so ready should drop once
	logic        split_pending;

	cpu_core uut (
		.clk,
		.rst,
		.instr_valid_i,
		.instr0_i,
		.instr1_i,
		.instr_ready_o,
		.retire_valid_o,
		.retire_rd0_o,
		.retire_rd1_o,
		.retire_data0_o,
		.retire_data1_o
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input word_t got, input word_t expected);
		if (got !== expected) begin
			stop_with_failure($sformatf("ERROR: %s is 0x%08h, expected 0x%08h",
				name, got, expected));
		end
	endtask

	function automatic instr_t encode(input opcode_t opc, input reg_addr_t rd,
			input reg_addr_t rs, input reg_addr_t rt, input imm_t imm);
		return {opc, rd, rs, rt, imm};
	endfunction

	function automatic reg_addr_t pick_reg();
		logic [31:0] r;
		r = $random(seed);
		// registers 0..7 most of the time so pairs collide often
		if (r[3:0] == 4'd0) begin
			return r[8:4];
		end
		return {2'b00, r[6:4]};
	endfunction

	function automatic instr_t random_instr();
		logic [31:0] r;
		opcode_t     opc;
		r = $random(seed);
		// now and then any opcode, unknown ones included
		if (r[31:29] == 3'd0) begin
			opc = r[3:0];
		end else begin
			opc = 4'd1 + r[7:4] % 4'd9;
		end
		return encode(opc, pick_reg(), pick_reg(), pick_reg(), r[28:16]);
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			instr_valid_i = 1'b0;
			instr0_i      = $random(seed);
			instr1_i      = $random(seed);
			split_pending = 1'b0;
		end
	endtask

	// ready only depends on registers, so it is settled at the falling edge
	task automatic send_pair(input instr_t i0, input instr_t i1);
		int   waits;
		logic split;
		waits = 0;
		@(negedge clk);
		instr_valid_i = 1'b1;
		instr0_i      = i0;
		instr1_i      = i1;
		while (!instr_ready_o) begin
			waits++;
			@(negedge clk);
		end
		check_value("instr_ready_o low cycles", word_t'(waits), split_pending ? 32'd1 : 32'd0);
		model_accept(i0, i1, cycle_cnt + 1, split);
		split_pending = split;
	endtask

	task automatic check_retire(input int lane);
		retire_t   exp;
		reg_addr_t rd;
		word_t     data;
		rd   = (lane == 0) ? retire_rd0_o : retire_rd1_o;
		data = (lane == 0) ? retire_data0_o : retire_data1_o;
		if (expect_q.size() == 0) begin
			stop_with_failure($sformatf("lane %0d retired with no instruction outstanding", lane));
		end else begin
			exp = expect_q.pop_front();
			check_value($sformatf("retire_valid_o[%0d] edge", lane), word_t'(cycle_cnt),
				word_t'(exp.cycle));
			check_value("retire_valid_o lane", word_t'(lane), word_t'(exp.lane));
			check_value($sformatf("retire_rd%0d_o", lane), word_t'(rd), word_t'(exp.rd));
			check_value($sformatf("retire_data%0d_o", lane), data, exp.data);
		end
	endtask

	always @(negedge clk) begin
		if (!rst) begin
			for (int l = 0; l < ISSUE_NUM; l++) begin
				if (retire_valid_o[l]) begin
					check_retire(l);
				end
			end
			if (expect_q.size() != 0 && expect_q[0].cycle <= cycle_cnt) begin
				stop_with_failure($sformatf("instruction due at edge %0d did not retire",
					expect_q[0].cycle));
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		stop_with_failure("timeout, the test did not finish in the expected number of cycles");
	end

	initial begin
		logic [31:0] gap;
		seed          = 32'h8e7a_cdfe;
		clk           = 1'b0;
		rst           = 1'b1;
		instr_valid_i = 1'b0;
		instr0_i      = '0;
		instr1_i      = '0;
		cycle_cnt     = 0;
		split_pending = 1'b0;
		model_reset();
		repeat (10) @(negedge clk);
		rst = 1'b0;
		idle_cycles(1);
		check_value("retire_valid_o", word_t'(retire_valid_o), '0);
		check_value("instr_ready_o", word_t'(instr_ready_o), 32'd1);

		// independent pair, r2 = -3
		send_pair(encode(OPC_ADDI, 5'd1, 5'd0, 5'd0, 13'd5),
			encode(OPC_ADDI, 5'd2, 5'd0, 5'd0, 13'h1ffd));
		idle_cycles(4);

		// forwarding at distance one, then r3 at distance two
		send_pair(encode(OPC_ADDI, 5'd3, 5'd1, 5'd0, 13'd7),
			encode(OPC_LUI, 5'd4, 5'd0, 5'd0, 13'h0abc));
		send_pair(encode(OPC_ADD, 5'd5, 5'd3, 5'd4, 13'd0),
			encode(OPC_SUB, 5'd6, 5'd1, 5'd2, 13'd0));
		send_pair(encode(OPC_XOR, 5'd7, 5'd5, 5'd3, 13'd0),
			encode(OPC_OR, 5'd1, 5'd5, 5'd0, 13'd0));
		idle_cycles(2);

		// split pairs, one followed directly by the next pair
		send_pair(encode(OPC_ADDI, 5'd2, 5'd1, 5'd0, 13'd100),
			encode(OPC_ADD, 5'd3, 5'd2, 5'd2, 13'd0));
		send_pair(encode(OPC_SLL, 5'd4, 5'd3, 5'd1, 13'd0),
			encode(OPC_AND, 5'd5, 5'd2, 5'd3, 13'd0));
		send_pair(encode(OPC_SUB, 5'd6, 5'd5, 5'd4, 13'd0),
			encode(OPC_XOR, 5'd7, 5'd6, 5'd1, 13'd0));
		idle_cycles(3);

		// both lanes write r6, lane 1 must stick
		send_pair(encode(OPC_ADDI, 5'd6, 5'd0, 5'd0, 13'd11),
			encode(OPC_ADDI, 5'd6, 5'd0, 5'd0, 13'd22));
		send_pair(encode(OPC_ADD, 5'd7, 5'd6, 5'd0, 13'd0),
			encode(OPC_NOP, 5'd3, 5'd6, 5'd6, 13'd0));
		idle_cycles(3);
		send_pair(encode(OPC_OR, 5'd1, 5'd6, 5'd6, 13'd0),
			encode(OPC_ADD, 5'd2, 5'd6, 5'd7, 13'd0));

		// r0 writes, signed compare, unknown opcode
		send_pair(encode(OPC_ADDI, 5'd0, 5'd1, 5'd0, 13'd55),
			encode(OPC_ADD, 5'd2, 5'd0, 5'd1, 13'd0));
		send_pair(encode(OPC_ADDI, 5'd1, 5'd0, 5'd0, 13'h1ffb),
			encode(OPC_ADDI, 5'd2, 5'd0, 5'd0, 13'd3));
		send_pair(encode(OPC_SLT, 5'd3, 5'd1, 5'd2, 13'd0),
			encode(OPC_SLT, 5'd4, 5'd2, 5'd1, 13'd0));
		send_pair(encode(4'hc, 5'd5, 5'd1, 5'd2, 13'd9),
			encode(OPC_ADD, 5'd6, 5'd5, 5'd0, 13'd0));
		idle_cycles(2);

		for (int n = 0; n < RANDOM_PAIRS; n++) begin
			send_pair(random_instr(), random_instr());
			gap = $random(seed);
			if (gap[2:0] == 3'd0) begin
				idle_cycles(1 + gap[3]);
			end
		end
		idle_cycles(6);

		if (expect_q.size() != 0) begin
			stop_with_failure($sformatf("%0d instructions never retired", expect_q.size()));
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule
